// File: design/tile_pkg.sv
`default_nettype none

package tile_pkg;

    //////////////////////////////////////////////////////////////////////
    // source tile geometry
    //////////////////////////////////////////////////////////////////////

    // element width seen by the execution core
    localparam int DATA_W = 32;

    // host write width of two elements per line
    // low half is the even element and high half the odd one
    localparam int LINE_W = 64;

endpackage

`default_nettype wire

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // reduction operations of the execution core
    //////////////////////////////////////////////////////////////////////

    // width of the operation select
    localparam int OP_W = 2;

    // all four reductions start from an accumulator of zero
    typedef enum logic [OP_W-1:0] {
        // sum modulo 2^32
        OP_SUM = 2'd0,
        // unsigned maximum
        OP_MAX = 2'd1,
        // xor of all elements
        OP_XOR = 2'd2,
        // count of nonzero elements
        OP_CNT = 2'd3
    } op_e;

endpackage

`default_nettype wire

// File: design/src_buf.sv
`default_nettype none
`timescale 1ns/10ps

module src_buf
    import tile_pkg::*;
#(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              wr_v,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [LINE_W-1:0] wr_line,
    input  logic              exec,
    input  logic [ADDR_W:0]   exec_addr,
    input  logic              bank,
    output logic [DATA_W-1:0] exec_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    // bank 0 halves
    logic [DATA_W-1:0] b0_even [DEPTH];
    logic [DATA_W-1:0] b0_odd  [DEPTH];

    // bank 1 halves
    logic [DATA_W-1:0] b1_even [DEPTH];
    logic [DATA_W-1:0] b1_odd  [DEPTH];

    // line address of the element being read
    logic [ADDR_W-1:0] rd_line;

    assign rd_line = exec_addr[ADDR_W:1];

    //////////////////////////////////////////////////////////////////////
    // host writes, fill bank only
    //////////////////////////////////////////////////////////////////////

    // bank 1 executing, fill bank 0
    always_ff @(posedge clk) begin
        if (wr_v && bank) begin
            b0_even[wr_addr] <= wr_line[DATA_W-1:0];
            b0_odd[wr_addr]  <= wr_line[LINE_W-1:DATA_W];
        end
    end

    // bank 0 executing, fill bank 1
    always_ff @(posedge clk) begin
        if (wr_v && !bank) begin
            b1_even[wr_addr] <= wr_line[DATA_W-1:0];
            b1_odd[wr_addr]  <= wr_line[LINE_W-1:DATA_W];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered element read from the execute bank
    //////////////////////////////////////////////////////////////////////

    // holds last word while exec is low
    always_ff @(posedge clk) begin
        if (exec) begin
            case ({bank, exec_addr[0]})
                2'b00:   exec_data <= b0_even[rd_line];
                2'b01:   exec_data <= b0_odd[rd_line];
                2'b10:   exec_data <= b1_even[rd_line];
                default: exec_data <= b1_odd[rd_line];
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/exec_core.sv
`default_nettype none
`timescale 1ns/10ps

module exec_core
    import tile_pkg::*, core_pkg::*;
#(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start,
    input  op_e               op,
    input  logic [ADDR_W:0]   base,
    input  logic [ADDR_W+1:0] len,
    input  logic              swap,
    input  logic [DATA_W-1:0] exec_data,
    output logic              exec,
    output logic [ADDR_W:0]   exec_addr,
    output logic              bank,
    output logic              busy,
    output logic              done,
    output logic [DATA_W-1:0] result
);

    // job acceptance
    logic              start_ok;
    op_e               op_q;

    // address stage
    logic [ADDR_W+1:0] rem;
    logic              rem_last;

    // data stage, one cycle behind the address stage
    logic              data_v;
    logic              data_last;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] folded;

    // swap request waiting for the job to finish
    logic              pending;

    //////////////////////////////////////////////////////////////////////
    // reduction step
    //////////////////////////////////////////////////////////////////////

    function automatic logic [DATA_W-1:0] fold(
        input op_e               f_op,
        input logic [DATA_W-1:0] acc_in,
        input logic [DATA_W-1:0] elem
    );
        logic [DATA_W-1:0] res;
        case (f_op)
            OP_SUM:  res = acc_in + elem;
            OP_MAX:  res = (elem > acc_in) ? elem : acc_in;
            OP_XOR:  res = acc_in ^ elem;
            OP_CNT:  res = acc_in + {{(DATA_W-1){1'b0}}, |elem};
            default: res = acc_in;
        endcase
        return res;
    endfunction

    // no new job while running or while a swap waits
    assign start_ok = start && !busy && !pending;
    assign rem_last = (rem == (ADDR_W+2)'(1));
    assign folded   = fold(op_q, acc, exec_data);

    //////////////////////////////////////////////////////////////////////
    // address sequencer
    //////////////////////////////////////////////////////////////////////

    // one idle cycle after accept, then len cycles of exec
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            exec <= 1'b0;
            rem  <= '0;
        end else begin
            if (start_ok) begin
                busy <= 1'b1;
                rem  <= len;
            end else if (exec) begin
                rem <= rem - 1'b1;
                if (rem_last) begin
                    exec <= 1'b0;
                end
            end else if (busy && rem != '0) begin
                exec <= 1'b1;
            end

            // busy drops together with done
            if (data_v && data_last) begin
                busy <= 1'b0;
            end
        end
    end

    // next element address, wraps over both halves
    always_ff @(posedge clk) begin
        if (start_ok) begin
            exec_addr <= base;
            op_q      <= op;
        end else if (exec) begin
            exec_addr <= exec_addr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // accumulator and result
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_v    <= 1'b0;
            data_last <= 1'b0;
            done      <= 1'b0;
            result    <= '0;
        end else begin
            // read data shows up one cycle after the address
            data_v    <= exec;
            data_last <= exec && rem_last;
            done      <= data_v && data_last;
            if (data_v && data_last) begin
                result <= folded;
            end
        end
    end

    // identity is zero for every op
    always_ff @(posedge clk) begin
        if (start_ok) begin
            acc <= '0;
        end else if (data_v) begin
            acc <= folded;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bank swap
    //////////////////////////////////////////////////////////////////////

    // idle swap toggles at once, busy swap waits until after done
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank    <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (!busy && (swap || pending)) begin
                bank    <= ~bank;
                pending <= 1'b0;
            end else if (busy && swap) begin
                // repeated requests fold into one toggle
                pending <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/tile_top.sv
`default_nettype none
`timescale 1ns/10ps

module tile_top
    import tile_pkg::*, core_pkg::*;
#(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              arst_n,
    // host write side
    input  logic              wr_v,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [LINE_W-1:0] wr_line,
    // job control
    input  logic              start,
    input  op_e               op,
    input  logic [ADDR_W:0]   base,
    input  logic [ADDR_W+1:0] len,
    input  logic              swap,
    // status and result
    output logic              bank,
    output logic              busy,
    output logic              done,
    output logic [DATA_W-1:0] result
);

    //////////////////////////////////////////////////////////////////////
    // core to buffer read path
    //////////////////////////////////////////////////////////////////////

    logic              exec;
    logic [ADDR_W:0]   exec_addr;
    logic [DATA_W-1:0] exec_data;

    // double-buffered element store
    src_buf #(
        .ADDR_W    (ADDR_W)
    ) i_src_buf (
        .clk       (clk),
        .wr_v      (wr_v),
        .wr_addr   (wr_addr),
        .wr_line   (wr_line),
        .exec      (exec),
        .exec_addr (exec_addr),
        .bank      (bank),
        .exec_data (exec_data)
    );

    // sequencer, reduction and swap control
    exec_core #(
        .ADDR_W    (ADDR_W)
    ) i_exec_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .op        (op),
        .base      (base),
        .len       (len),
        .swap      (swap),
        .exec_data (exec_data),
        .exec      (exec),
        .exec_addr (exec_addr),
        .bank      (bank),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

endmodule

`default_nettype wire

// File: sim/tile_asserts.sv
`default_nettype none
`timescale 1ns/10ps

module tile_asserts (
    input logic clk,
    input logic arst_n,
    input logic exec,
    input logic busy,
    input logic done,
    input logic bank
);

    // failure tallies, summed for the testbench
    int unsigned exec_fails  = 0;
    int unsigned done_fails  = 0;
    int unsigned bank_fails  = 0;
    int unsigned reset_fails = 0;
    int unsigned fail_count;

    assign fail_count = exec_fails + done_fails + bank_fails + reset_fails;

    //////////////////////////////////////////////////////////////////////
    // control behavior of the execution core
    //////////////////////////////////////////////////////////////////////

    // address stage only inside a job
    a_exec_in_busy: assert property (
        @(posedge clk) disable iff (!arst_n) exec |-> busy
    ) else begin
        $error("exec high while the core is idle");
        exec_fails++;
    end

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) done |=> !done
    ) else begin
        $error("done held for more than one cycle");
        done_fails++;
    end

    // a swap requested mid-job waits for done
    a_bank_stable: assert property (
        @(posedge clk) disable iff (!arst_n) busy |=> $stable(bank)
    ) else begin
        $error("bank changed during a job");
        bank_fails++;
    end

    a_reset_quiet: assert property (
        @(posedge clk) !arst_n |-> (!exec && !busy && !done)
    ) else begin
        $error("control outputs active in reset");
        reset_fails++;
    end

endmodule

`default_nettype wire

// File: sim/tile_tb.sv
`default_nettype none
`timescale 1ns/10ps

module tile_tb
    import tile_pkg::*, core_pkg::*;
();

    localparam int ADDR_W       = 6;
    localparam int DEPTH        = 2 ** ADDR_W;
    localparam int CLK_PERIOD   = 20;
    localparam int NUM_BATCH    = 48;
    // worst batch: random fill, idle swap, longest job and its tail
    localparam int BATCH_CYC    = 16 + 8 + (2 * DEPTH + 8);
    // directed phases counted as a few extra batches
    localparam int WATCHDOG_CYC = (NUM_BATCH + 12) * BATCH_CYC;

    logic              clk;
    logic              arst_n;
    logic              wr_v;
    logic [ADDR_W-1:0] wr_addr;
    logic [LINE_W-1:0] wr_line;
    logic              start;
    op_e               op;
    logic [ADDR_W:0]   base;
    logic [ADDR_W+1:0] len;
    logic              swap;
    logic              bank;
    logic              busy;
    logic              done;
    logic [DATA_W-1:0] result;

    integer            seed;

    // element view of both banks plus the expected bank select
    logic [DATA_W-1:0] model_mem [2][2*DEPTH];
    logic              model_bank;

    tile_top #(
        .ADDR_W  (ADDR_W)
    ) i_tile_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_v    (wr_v),
        .wr_addr (wr_addr),
        .wr_line (wr_line),
        .start   (start),
        .op      (op),
        .base    (base),
        .len     (len),
        .swap    (swap),
        .bank    (bank),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    bind exec_core tile_asserts i_tile_asserts (
        .clk    (clk),
        .arst_n (arst_n),
        .exec   (exec),
        .busy   (busy),
        .done   (done),
        .bank   (bank)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("timeout: the run did not finish within the watchdog limit");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and checking
    //////////////////////////////////////////////////////////////////////

    task automatic check(input string what, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // one element in eight is zero so the count op sees both cases
    function automatic logic [DATA_W-1:0] rand_elem();
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] == 3'd0) return '0;
        return $random(seed);
    endfunction

    // reduction over the model bank, element address wraps
    function automatic logic [DATA_W-1:0] reduce(input op_e r_op, input logic bnk,
                                                 input logic [ADDR_W:0] r_base,
                                                 input logic [ADDR_W+1:0] r_len);
        logic [DATA_W-1:0] acc;
        logic [DATA_W-1:0] e;
        logic [ADDR_W:0]   a;
        acc = '0;
        a   = r_base;
        for (int i = 0; i < int'(r_len); i++) begin
            e = model_mem[bnk][a];
            case (r_op)
                OP_SUM:  acc = acc + e;
                OP_MAX:  acc = (e > acc) ? e : acc;
                OP_XOR:  acc = acc ^ e;
                OP_CNT:  acc = (e != '0) ? acc + 32'd1 : acc;
                default: acc = acc;
            endcase
            a = a + 1'b1;
        end
        return acc;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////

    // drive one line, model puts it into the fill bank
    task automatic write_line(input logic [ADDR_W-1:0] a, input logic [LINE_W-1:0] line);
        wr_v    <= 1'b1;
        wr_addr <= a;
        wr_line <= line;
        model_mem[~model_bank][{a, 1'b0}] = line[DATA_W-1:0];
        model_mem[~model_bank][{a, 1'b1}] = line[LINE_W-1:DATA_W];
    endtask

    task automatic fill_lines(input int n, input bit seq);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            r = $random(seed);
            write_line(seq ? ADDR_W'(i) : r[ADDR_W-1:0], {rand_elem(), rand_elem()});
        end
        @(posedge clk);
        wr_v <= 1'b0;
    endtask

    task automatic swap_idle();
        @(posedge clk);
        swap <= 1'b1;
        @(posedge clk);
        swap <= 1'b0;
        model_bank = ~model_bank;
        @(negedge clk);
        check("bank after idle swap", 32'(bank), 32'(model_bank));
    endtask

    // job with fixed latency, optional writes, swap and ignored starts while busy
    task automatic run_job(input op_e j_op, input logic [ADDR_W:0] j_base,
                           input logic [ADDR_W+1:0] j_len, input int n_wr,
                           input bit swap_busy);
        logic [DATA_W-1:0] expected;
        logic [31:0]       r;
        int                last;
        expected = reduce(j_op, model_bank, j_base, j_len);
        last     = int'(j_len) + 2;
        @(posedge clk);
        start <= 1'b1;
        op    <= j_op;
        base  <= j_base;
        len   <= j_len;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check("busy after start", 32'(busy), 32'd1);
        for (int i = 1; i <= last; i++) begin
            @(posedge clk);
            wr_v  <= 1'b0;
            swap  <= 1'b0;
            start <= 1'b0;
            if (i <= n_wr) begin
                r = $random(seed);
                write_line(r[ADDR_W-1:0], {rand_elem(), rand_elem()});
            end
            if (i == 1 && swap_busy) swap <= 1'b1;
            if (i == 2) begin
                start <= 1'b1;
                op    <= op_e'(~j_op);
                base  <= j_base + 1'b1;
            end
            // sampled on the cycle where only the pending swap blocks it
            if (i == last && swap_busy) start <= 1'b1;
            @(negedge clk);
            check("done timing", 32'(done), 32'(i == last));
            check("busy during job", 32'(busy), 32'(i < last));
        end
        check("result", result, expected);
        check("bank at done", 32'(bank), 32'(model_bank));
        @(posedge clk);
        start <= 1'b0;
        if (swap_busy) model_bank = ~model_bank;
        repeat (2) begin
            @(negedge clk);
            check("bank after job", 32'(bank), 32'(model_bank));
            check("no extra job", 32'({busy, done}), 32'd0);
        end
    endtask

    task automatic random_job(input op_e j_op, input bit wr_during, input bit swap_busy);
        logic [31:0]       r;
        logic [ADDR_W+1:0] j_len;
        r     = $random(seed);
        j_len = {1'b0, r[2*ADDR_W+1:ADDR_W+1]} + 1'b1;
        run_job(j_op, r[ADDR_W:0], j_len, wr_during ? int'(j_len) : 0, swap_busy);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        seed       = 32'hc4b5_d790;
        model_bank = 1'b0;
        arst_n  <= 1'b0;
        wr_v    <= 1'b0;
        wr_addr <= '0;
        wr_line <= '0;
        start   <= 1'b0;
        op      <= OP_SUM;
        base    <= '0;
        len     <= '0;
        swap    <= 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("bank after reset", 32'(bank), 32'd0);
        check("busy/done after reset", 32'({busy, done}), 32'd0);
        check("result after reset", result, '0);

        // bank 1 filled and made executable, then bank 0 filled
        fill_lines(DEPTH, 1'b1);
        swap_idle();
        fill_lines(DEPTH, 1'b1);
        for (int k = 0; k < 4; k++) begin
            random_job(op_e'(k[1:0]), 1'b0, 1'b0);
        end
        run_job(OP_SUM, 7'(2 * DEPTH - 3), 8'd8, 0, 1'b0);
        random_job(OP_XOR, 1'b1, 1'b0);
        random_job(OP_MAX, 1'b1, 1'b1);

        for (int b = 0; b < NUM_BATCH; b++) begin
            r = $random(seed);
            fill_lines(int'(r[3:0]), 1'b0);
            if (r[4]) swap_idle();
            random_job(op_e'(r[6:5]), r[7], r[8]);
        end

        if (i_tile_top.i_exec_core.i_tile_asserts.fail_count != 0) begin
            $display("[FAIL] %0t ns assertion failures in exec_core: %0d", $time,
                     i_tile_top.i_exec_core.i_tile_asserts.fail_count);
            $display("*** FAILED ***");
            $fatal(1, "assertion failures");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
design/tile_pkg.sv
design/core_pkg.sv
design/src_buf.sv
design/exec_core.sv
design/tile_top.sv
sim/tile_asserts.sv
sim/tile_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tile_tb -f vlog.f -o tile_sim
	./obj_dir/tile_sim | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
